// File: files.f
hdl/cpuPkg.sv
hdl/stepCounter.sv
hdl/controlUnit.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/instrRegs.sv
hdl/memInterface.sv
hdl/busUnit.sv
hdl/busCpu.sv
tests/busCpuTb.sv

// File: hdl/aluUnit.sv
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
    input  wire clock,
    input  wire rstN,
    input  wire cpuPkg::ctrlSignals_t ctrl,
    input  wire [cpuPkg::wordWidth-1:0] bus,
    output logic [cpuPkg::wordWidth-1:0] zValue
);
    import cpuPkg::*;

    logic [wordWidth-1:0] y;       // first operand.
    logic [wordWidth-1:0] result;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            y <= '0;
        end else if (ctrl.yIn) begin
            y <= bus;
        end
    end

    always_comb begin
        case (ctrl.aluOp)
            aluAdd: result = y + bus;
            aluSub: result = y - bus;
            aluAnd: result = y & bus;
            aluOr: result = y | bus;
            aluInc: result = bus + 1'b1;  // pc increment, y unused.
            default: result = y + bus;
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            zValue <= '0;
        end else if (ctrl.zIn) begin
            zValue <= result;  // z register.
        end
    end
endmodule

`default_nettype wire

// File: hdl/busCpu.sv
`timescale 1ns/100ps
`default_nettype none

module busCpu (
    input  wire clock,
    input  wire rstN,
    output logic [cpuPkg::wordWidth-1:0] memAddr,
    output logic [cpuPkg::wordWidth-1:0] memWData,
    input  wire [cpuPkg::wordWidth-1:0] memRData,
    output logic memReq,
    output logic memWrite,
    input  wire memDone,
    output logic [cpuPkg::wordWidth-1:0] outData,
    output logic outStrobe,
    output logic halted
);
    import cpuPkg::*;

    ctrlSignals_t ctrl;
    instrFields_t fields;
    logic [stepWidth-1:0] step;
    logic stepClear;
    logic stepHold;
    logic con;
    logic [wordWidth-1:0] bus;
    logic [wordWidth-1:0] regData;
    logic [wordWidth-1:0] zValue;
    logic [wordWidth-1:0] mdrValue;
    logic [wordWidth-1:0] pcValue;

    assign memWrite = ctrl.memWrite;  // level while the write is open.

    // every port name matches its net.
    stepCounter stepCounter_inst (.*);
    controlUnit controlUnit_inst (.*);
    registerFile registerFile_inst (.*);
    aluUnit aluUnit_inst (.*);
    instrRegs instrRegs_inst (.*);
    memInterface memInterface_inst (.*);
    busUnit busUnit_inst (.*);
endmodule

`default_nettype wire

// File: hdl/busUnit.sv
`timescale 1ns/100ps
`default_nettype none

module busUnit (
    input  wire clock,
    input  wire rstN,
    input  wire cpuPkg::ctrlSignals_t ctrl,
    input  wire cpuPkg::instrFields_t fields,
    input  wire [cpuPkg::wordWidth-1:0] regData,
    input  wire [cpuPkg::wordWidth-1:0] zValue,
    input  wire [cpuPkg::wordWidth-1:0] mdrValue,
    input  wire [cpuPkg::wordWidth-1:0] pcValue,
    output logic [cpuPkg::wordWidth-1:0] bus,
    output logic con,
    output logic [cpuPkg::wordWidth-1:0] outData,
    output logic outStrobe
);
    import cpuPkg::*;

    // and-or mux, sources are one-hot.
    assign bus = ({wordWidth{ctrl.pcOut}} & pcValue)
               | ({wordWidth{ctrl.zOut}} & zValue)
               | ({wordWidth{ctrl.mdrOut}} & mdrValue)
               | ({wordWidth{ctrl.regOut}} & regData)
               | ({wordWidth{ctrl.cOut}} & fields.constant);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            con <= 1'b0;
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= ctrl.outIn;  // cycle after the out step.
            if (ctrl.conIn) begin
                case (fields.cond)
                    2'd0: con <= (bus == '0);  // branch if zero.
                    2'd1: con <= (bus != '0);  // branch if nonzero.
                    default: con <= 1'b0;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.outIn) begin
            outData <= bus;  // output port register.
        end
    end
endmodule

`default_nettype wire

// File: hdl/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
    input  wire clock,
    input  wire rstN,
    input  wire [cpuPkg::stepWidth-1:0] step,
    input  wire cpuPkg::instrFields_t fields,
    input  wire con,
    input  wire memDone,
    output cpuPkg::ctrlSignals_t ctrl,
    output logic stepClear,
    output logic stepHold,
    output logic memReq,
    output logic halted
);
    import cpuPkg::*;

    typedef enum logic [1:0] {sFetch, sExec, sHalted} state_t;

    state_t state;
    logic pending;       // memory request open.
    logic pendingWrite;  // open request is a write.
    logic goHalt;
    logic isAlu;         // add, sub, and, or.
    logic isAddr;        // Rb + C forms.
    logic isLd;
    logic isSt;
    logic isBr;
    aluOp_t aluSel;

    assign isAlu = fields.opcode inside {opAdd, opSub, opAnd, opOr};
    assign isAddr = fields.opcode inside {opLd, opSt, opAddi};
    assign isLd = (fields.opcode == opLd);
    assign isSt = (fields.opcode == opSt);
    assign isBr = (fields.opcode == opBr);

    always_comb begin
        case (fields.opcode)
            opSub: aluSel = aluSub;
            opAnd: aluSel = aluAnd;
            opOr: aluSel = aluOr;
            default: aluSel = aluAdd;  // addi, ld, st address.
        endcase
    end

    always_comb begin
        ctrl = '0;
        stepClear = 1'b0;
        goHalt = 1'b0;
        if (state == sFetch) begin
            case (step)
                stepT0: begin
                    ctrl.pcOut = 1'b1;
                    ctrl.marIn = 1'b1;
                    ctrl.aluOp = aluInc;  // z gets pc + 1.
                    ctrl.zIn = 1'b1;
                end
                stepT1: begin
                    ctrl.zOut = 1'b1;
                    ctrl.pcIn = 1'b1;
                    ctrl.memRead = 1'b1;  // instruction read.
                end
                stepT2: begin
                    ctrl.mdrOut = 1'b1;
                    ctrl.irIn = 1'b1;
                end
                default: ;
            endcase
        end else if (state == sExec) begin
            case (step)
                stepT3: begin
                    if (isAddr || isAlu) begin
                        ctrl.grb = 1'b1;      // Rb into y.
                        ctrl.baOut = isAddr;
                        ctrl.regOut = 1'b1;
                        ctrl.yIn = 1'b1;
                    end else begin
                        ctrl.gra = 1'b1;
                        ctrl.regOut = fields.opcode inside {opBr, opJr, opOut};
                        ctrl.conIn = isBr;
                        ctrl.pcIn = (fields.opcode == opJr);
                        ctrl.outIn = (fields.opcode == opOut);
                        goHalt = (fields.opcode == opHalt);
                        stepClear = !isBr;    // jr, out, halt, nop end here.
                    end
                end
                stepT4: begin
                    if (isAddr || isAlu) begin
                        ctrl.cOut = isAddr;   // C or Rc through the alu.
                        ctrl.grc = isAlu;
                        ctrl.regOut = isAlu;
                        ctrl.aluOp = aluSel;
                        ctrl.zIn = 1'b1;
                    end else begin
                        ctrl.pcOut = con;     // taken branch, pc into y.
                        ctrl.yIn = con;
                    end
                end
                stepT5: begin
                    if (isAddr || isAlu) begin
                        ctrl.zOut = 1'b1;
                        ctrl.marIn = isLd || isSt;
                        ctrl.gra = !(isLd || isSt);
                        ctrl.regIn = !(isLd || isSt);
                        stepClear = !(isLd || isSt);
                    end else begin
                        ctrl.cOut = con;      // pc + C into z.
                        ctrl.zIn = con;
                    end
                end
                stepT6: begin
                    ctrl.memRead = isLd;
                    ctrl.gra = isSt;          // Ra into mdr for the store.
                    ctrl.regOut = isSt;
                    ctrl.mdrIn = isSt;
                    ctrl.zOut = isBr && con;
                    ctrl.pcIn = isBr && con;
                    stepClear = isBr;
                end
                stepT7: begin
                    ctrl.mdrOut = isLd;       // load data into Ra.
                    ctrl.gra = isLd;
                    ctrl.regIn = isLd;
                    ctrl.memWrite = isSt;     // next fetch waits for it.
                    stepClear = 1'b1;
                end
                default: ;
            endcase
        end
        memReq = ctrl.memRead || ctrl.memWrite;  // first cycle of an access.
        if (pending) begin
            ctrl = '0;                           // no strobes while waiting.
            ctrl.memRead = !pendingWrite;
            ctrl.memWrite = pendingWrite;
            stepClear = 1'b0;
            goHalt = 1'b0;
            memReq = 1'b0;
        end
    end

    assign stepHold = pending || (state == sHalted);
    assign halted = (state == sHalted);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pending <= 1'b0;
            pendingWrite <= 1'b0;
        end else if (memReq) begin
            pending <= 1'b1;
            pendingWrite <= ctrl.memWrite;
        end else if (memDone) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= sFetch;
        end else begin
            case (state)
                sFetch: begin
                    if (step == stepT2 && !pending) begin
                        state <= sExec;   // ir loaded.
                    end
                end
                sExec: begin
                    if (goHalt) begin
                        state <= sHalted;
                    end else if (stepClear) begin
                        state <= sFetch;
                    end
                end
                default: state <= sHalted;  // stays until reset.
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (!rstN)
        $onehot0({ctrl.pcOut, ctrl.zOut, ctrl.mdrOut, ctrl.regOut, ctrl.cOut}))
        else $error("more than one bus source driven");
endmodule

`default_nettype wire

// File: hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;
    localparam int wordWidth = 32;   // data and address width.
    localparam int regCount = 16;
    localparam int regSelWidth = 4;  // Ra/Rb/Rc field width.
    localparam int stepWidth = 3;

    localparam int opMsb = 31;       // opcode field.
    localparam int opLsb = 27;
    localparam int raLsb = 23;
    localparam int rbLsb = 19;
    localparam int rcLsb = 15;
    localparam int constWidth = 19;  // C in bits 18..0.
    localparam int condLsb = 19;     // branch condition overlaps Rb.
    localparam int condWidth = 2;

    localparam logic [stepWidth-1:0] stepT0 = 3'd0;  // fetch, pc to mar.
    localparam logic [stepWidth-1:0] stepT1 = 3'd1;  // fetch, pc update and read.
    localparam logic [stepWidth-1:0] stepT2 = 3'd2;  // fetch, mdr to ir.
    localparam logic [stepWidth-1:0] stepT3 = 3'd3;
    localparam logic [stepWidth-1:0] stepT4 = 3'd4;
    localparam logic [stepWidth-1:0] stepT5 = 3'd5;
    localparam logic [stepWidth-1:0] stepT6 = 3'd6;
    localparam logic [stepWidth-1:0] stepT7 = 3'd7;

    typedef enum logic [4:0] {
        opLd = 5'd0, opSt = 5'd1, opAddi = 5'd2, opAdd = 5'd3, opSub = 5'd4,
        opAnd = 5'd5, opOr = 5'd6, opBr = 5'd7, opJr = 5'd8, opOut = 5'd9,
        opHalt = 5'd10
    } opcode_t;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluInc} aluOp_t;

    typedef struct packed {
        logic pcOut;    // bus sources, at most one.
        logic zOut;
        logic mdrOut;
        logic regOut;
        logic cOut;
        logic marIn;    // register loads.
        logic mdrIn;
        logic irIn;
        logic pcIn;
        logic yIn;
        logic zIn;
        logic regIn;
        logic conIn;
        logic outIn;
        logic gra;      // register selects.
        logic grb;
        logic grc;
        logic baOut;    // r0 reads zero as base.
        aluOp_t aluOp;
        logic memRead;  // level while a read is open.
        logic memWrite;
    } ctrlSignals_t;

    typedef struct packed {
        opcode_t opcode;
        logic [regSelWidth-1:0] ra;
        logic [regSelWidth-1:0] rb;
        logic [regSelWidth-1:0] rc;
        logic [wordWidth-1:0] constant;  // sign extended C.
        logic [condWidth-1:0] cond;
    } instrFields_t;
endpackage

`default_nettype wire

// File: hdl/instrRegs.sv
`timescale 1ns/100ps
`default_nettype none

module instrRegs (
    input  wire clock,
    input  wire rstN,
    input  wire cpuPkg::ctrlSignals_t ctrl,
    input  wire [cpuPkg::wordWidth-1:0] bus,
    output logic [cpuPkg::wordWidth-1:0] pcValue,
    output cpuPkg::instrFields_t fields
);
    import cpuPkg::*;

    logic [wordWidth-1:0] ir;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pcValue <= '0;
            ir <= '0;
        end else begin
            if (ctrl.pcIn) begin
                pcValue <= bus;
            end
            if (ctrl.irIn) begin
                ir <= bus;
            end
        end
    end

    always_comb begin
        fields.opcode = opcode_t'(ir[opMsb:opLsb]);  // unknown codes run as nop.
        fields.ra = ir[raLsb +: regSelWidth];
        fields.rb = ir[rbLsb +: regSelWidth];
        fields.rc = ir[rcLsb +: regSelWidth];
        fields.constant = {{(wordWidth - constWidth){ir[constWidth-1]}}, ir[constWidth-1:0]};
        fields.cond = ir[condLsb +: condWidth];
    end
endmodule

`default_nettype wire

// File: hdl/memInterface.sv
`timescale 1ns/100ps
`default_nettype none

module memInterface (
    input  wire clock,
    input  wire rstN,
    input  wire cpuPkg::ctrlSignals_t ctrl,
    input  wire [cpuPkg::wordWidth-1:0] bus,
    input  wire [cpuPkg::wordWidth-1:0] memRData,
    input  wire memDone,
    output logic [cpuPkg::wordWidth-1:0] mdrValue,
    output logic [cpuPkg::wordWidth-1:0] memAddr,
    output logic [cpuPkg::wordWidth-1:0] memWData
);
    import cpuPkg::*;

    logic [wordWidth-1:0] mar;

    always_ff @(posedge clock) begin
        if (ctrl.marIn) begin
            mar <= bus;
        end
    end

    always_ff @(posedge clock) begin
        if (memDone && ctrl.memRead) begin
            mdrValue <= memRData;  // read data, valid with done.
        end else if (ctrl.mdrIn) begin
            mdrValue <= bus;       // store data.
        end
    end

    assign memAddr = mar;
    assign memWData = mdrValue;

    // done only answers a request opened by the control unit.
    assert property (@(posedge clock) disable iff (!rstN)
        memDone |-> (ctrl.memRead || ctrl.memWrite))
        else $error("memDone without an open request");
endmodule

`default_nettype wire

// File: hdl/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
    input  wire clock,
    input  wire rstN,
    input  wire cpuPkg::ctrlSignals_t ctrl,
    input  wire cpuPkg::instrFields_t fields,
    input  wire [cpuPkg::wordWidth-1:0] bus,
    output logic [cpuPkg::wordWidth-1:0] regData
);
    import cpuPkg::*;

    logic [wordWidth-1:0] regs [regCount];
    logic [regSelWidth-1:0] sel;

    // gra wins over grb, rc otherwise.
    assign sel = ctrl.gra ? fields.ra : (ctrl.grb ? fields.rb : fields.rc);

    // base register r0 reads as zero.
    assign regData = (ctrl.baOut && sel == '0) ? '0 : regs[sel];

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regIn) begin
            regs[sel] <= bus;  // write on the edge.
        end
    end
endmodule

`default_nettype wire

// File: hdl/stepCounter.sv
`timescale 1ns/100ps
`default_nettype none

module stepCounter (
    input  wire clock,
    input  wire rstN,
    input  wire stepClear,
    input  wire stepHold,
    output logic [cpuPkg::stepWidth-1:0] step
);
    import cpuPkg::*;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            step <= stepT0;
        end else if (stepHold) begin
            step <= step;         // memory pending or halted.
        end else if (stepClear) begin
            step <= stepT0;       // last step of the instruction.
        end else begin
            step <= step + 1'b1;
        end
    end

    // the counter must be cleared at T7, never wrap past it.
    assert property (@(posedge clock) disable iff (!rstN)
        (step == stepT7 && !stepHold) |-> stepClear)
        else $error("step counter passed T7");
endmodule

`default_nettype wire

// File: tests/busCpuTb.sv
`timescale 1ns/100ps
`default_nettype none

module busCpuTb;
    import cpuPkg::*;

    localparam int clockPeriod = 40;
    localparam int memWords = 256;        // word addressed through memAddr[7:0].
    localparam int cyclesPerInstr = 24;   // fetch and ld/st waits at 4 cycles each.
    localparam int haltWatch = 50;
    localparam int modelLimit = 2000;

    logic clock = 1'b0;
    logic rstN = 1'b0;
    logic [wordWidth-1:0] memAddr;
    logic [wordWidth-1:0] memWData;
    logic [wordWidth-1:0] memRData = '0;
    logic memReq;
    logic memWrite;
    logic memDone = 1'b0;
    logic [wordWidth-1:0] outData;
    logic outStrobe;
    logic halted;

    logic [31:0] prog [$];                // program under construction.
    logic [31:0] progImage [memWords];
    logic [31:0] mem [memWords];          // memory seen by the DUT.
    logic [31:0] expOut [$];
    logic [31:0] expWrAddr [$];
    logic [31:0] expWrData [$];
    logic [31:0] actOut [$];
    logic [31:0] actWrAddr [$];
    logic [31:0] actWrData [$];
    logic [31:0] firstOut [$];
    logic [31:0] reqAddr;
    logic reqWrite = 1'b0;                // kind of the open request.
    bit fixedLatency = 1'b0;
    int left = 0;                         // cycles until memDone.
    int cycleCount = 0;
    int cycleLimit = 1000;
    int checks = 0;
    int errors = 0;
    int tests = 0;

    busCpu busCpu_inst (.*);

    always #(clockPeriod / 2) clock = ~clock;

    // memory model answering each request after 1 to 4 cycles.
    always @(posedge clock) begin
        memDone <= 1'b0;
        if (memDone) begin
            checkValue("memWrite", memWrite, reqWrite);  // level held until done.
        end
        if (!rstN) begin
            left = 0;
        end else if (memReq) begin
            reqAddr = memAddr;
            reqWrite = memWrite;
            if (memWrite) begin
                mem[memAddr[7:0]] = memWData;
                actWrAddr.push_back(memAddr);
                actWrData.push_back(memWData);
            end
            left = fixedLatency ? 1 : $urandom_range(1, 4);
        end
        if (left != 0) begin
            left = left - 1;
            if (left == 0) begin
                memDone <= 1'b1;
                memRData <= mem[reqAddr[7:0]];  // valid with done.
            end
        end
        if (outStrobe) begin
            actOut.push_back(outData);
        end
    end

    // watchdog with a limit set per program.
    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: program did not halt within %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] encodeImm(input logic [4:0] op, input logic [3:0] ra,
                                              input logic [3:0] rb, input logic [31:0] c);
        return {op, ra, rb, c[18:0]};
    endfunction

    function automatic logic [31:0] encodeReg(input logic [4:0] op, input logic [3:0] ra,
                                              input logic [3:0] rb, input logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic logic [31:0] encodeBranch(input logic [3:0] ra, input logic [1:0] cond,
                                                 input logic [31:0] c);
        return {opBr, ra, 2'b00, cond, c[18:0]};
    endfunction

    // unused words decode as halt with low bits hashed from the address.
    function automatic logic [31:0] fillWord(input int addr);
        logic [31:0] mix;
        mix = addr * 32'h9e3779b1;
        return {opHalt, mix[26:0]};
    endfunction

    // reference ISA model over a copy of the program image.
    task automatic runModel(output int executed);
        logic [31:0] regs [regCount];
        logic [31:0] mm [memWords];
        logic [31:0] pc;
        logic [31:0] ir;
        logic [31:0] c;
        logic [31:0] base;
        logic [31:0] addr;
        logic [4:0] op;
        logic [3:0] ra;
        logic [3:0] rb;
        logic [3:0] rc;
        logic [1:0] cond;
        bit stop;
        for (int i = 0; i < regCount; i++) begin
            regs[i] = '0;
        end
        mm = progImage;
        expOut.delete();
        expWrAddr.delete();
        expWrData.delete();
        pc = '0;
        executed = 0;
        stop = 1'b0;
        while (!stop && executed < modelLimit) begin
            ir = mm[pc[7:0]];
            pc = pc + 1;                           // br offsets from here.
            executed++;
            op = ir[31:27];
            ra = ir[26:23];
            rb = ir[22:19];
            rc = ir[18:15];
            cond = ir[20:19];
            c = {{13{ir[18]}}, ir[18:0]};
            base = (rb == 4'd0) ? '0 : regs[rb];   // r0 as base is zero.
            addr = base + c;
            case (op)
                opLd: regs[ra] = mm[addr[7:0]];
                opSt: begin
                    mm[addr[7:0]] = regs[ra];
                    expWrAddr.push_back(addr);
                    expWrData.push_back(regs[ra]);
                end
                opAddi: regs[ra] = addr;
                opAdd: regs[ra] = regs[rb] + regs[rc];
                opSub: regs[ra] = regs[rb] - regs[rc];
                opAnd: regs[ra] = regs[rb] & regs[rc];
                opOr: regs[ra] = regs[rb] | regs[rc];
                opBr: begin
                    if ((cond == 2'd0 && regs[ra] == '0) || (cond == 2'd1 && regs[ra] != '0)) begin
                        pc = pc + c;
                    end
                end
                opJr: pc = regs[ra];
                opOut: expOut.push_back(regs[ra]);
                opHalt: stop = 1'b1;
                default: ;                         // nop.
            endcase
        end
    endtask

    task automatic applyReset();
        @(posedge clock);
        rstN <= 1'b0;
        actOut.delete();
        actWrAddr.delete();
        actWrData.delete();
        repeat (8) @(posedge clock);
        rstN <= 1'b1;
    endtask

    task automatic runProgram(input string name, input bit fixedLat);
        int executed;
        int errBefore;
        int n;
        errBefore = errors;
        for (int a = 0; a < memWords; a++) begin
            progImage[a] = (a < prog.size()) ? prog[a] : fillWord(a);
        end
        mem = progImage;
        fixedLatency = fixedLat;
        runModel(executed);
        cycleLimit = executed * cyclesPerInstr + haltWatch + 40;
        cycleCount = 0;
        applyReset();
        while (!halted) begin
            @(posedge clock);
        end
        repeat (haltWatch) begin
            @(posedge clock);
            checkValue("memReq", memReq, 1'b0);  // nothing after halt.
            checkValue("halted", halted, 1'b1);
        end
        checkValue("out count", actOut.size(), expOut.size());
        n = (actOut.size() < expOut.size()) ? actOut.size() : expOut.size();
        for (int i = 0; i < n; i++) begin
            checkValue($sformatf("outData[%0d]", i), actOut[i], expOut[i]);
        end
        checkValue("write count", actWrAddr.size(), expWrAddr.size());
        n = (actWrAddr.size() < expWrAddr.size()) ? actWrAddr.size() : expWrAddr.size();
        for (int i = 0; i < n; i++) begin
            checkValue($sformatf("memAddr[%0d]", i), actWrAddr[i], expWrAddr[i]);
            checkValue($sformatf("memWData[%0d]", i), actWrData[i], expWrData[i]);
        end
        tests++;
        $display("%-16s %0d instr, %0d outs, %0d writes, %s", name, executed,
                 expOut.size(), expWrAddr.size(), (errors == errBefore) ? "ok" : "mismatch");
    endtask

    task automatic initRegs();
        for (int r = 1; r < regCount; r++) begin
            prog.push_back(encodeImm(opAddi, r, 0, $urandom));
        end
    endtask

    task automatic buildAluProgram();
        logic [3:0] ra;
        int kind;
        prog.delete();
        initRegs();
        repeat (20) begin
            ra = $urandom_range(0, 15);
            kind = $urandom_range(0, 4);
            case (kind)
                0: prog.push_back(encodeImm(opAddi, ra, $urandom_range(0, 15), $urandom));
                1: prog.push_back(encodeReg(opAdd, ra, $urandom_range(0, 15), $urandom_range(0, 15)));
                2: prog.push_back(encodeReg(opSub, ra, $urandom_range(0, 15), $urandom_range(0, 15)));
                3: prog.push_back(encodeReg(opAnd, ra, $urandom_range(0, 15), $urandom_range(0, 15)));
                default: prog.push_back(encodeReg(opOr, ra, $urandom_range(0, 15),
                                                  $urandom_range(0, 15)));
            endcase
            prog.push_back(encodeImm(opOut, ra, 0, 0));
        end
        prog.push_back(encodeImm(opHalt, 0, 0, 0));
    endtask

    task automatic buildMemProgram();
        logic [3:0] rb;
        logic [3:0] rd;
        int off;
        prog.delete();
        initRegs();
        repeat (8) begin
            rb = $urandom_range(0, 15);
            if (rb != 4'd0) begin
                prog.push_back(encodeImm(opAddi, rb, 0, 144 + $urandom_range(0, 63)));
                off = $urandom_range(0, 31) - 16;  // negative offsets too.
            end else begin
                off = 128 + $urandom_range(0, 95);
            end
            rd = $urandom_range(1, 15);
            prog.push_back(encodeImm(opSt, $urandom_range(0, 15), rb, off));
            if ($urandom_range(0, 3) == 0) begin
                off = off + 1;                   // neighbour word that often holds fill data.
            end
            prog.push_back(encodeImm(opLd, rd, rb, off));
            prog.push_back(encodeImm(opOut, rd, 0, 0));
        end
        prog.push_back(encodeImm(opHalt, 0, 0, 0));
    endtask

    task automatic buildBranchProgram();
        int val;
        prog.delete();
        prog.push_back(encodeImm(opAddi, 2, 0, 32'h111));  // skipped marker.
        prog.push_back(encodeImm(opAddi, 3, 0, 32'h222));
        // each condition against zero and nonzero values.
        for (int i = 0; i < 8; i++) begin
            val = $urandom_range(1, 2000);
            if (i[2]) begin
                val = -val;                                 // negative values too.
            end
            if (i[1]) begin
                val = 0;                                    // zero register.
            end
            prog.push_back(encodeImm(opAddi, 1, 0, val));
            prog.push_back(encodeBranch(1, i[0], 1));
            prog.push_back(encodeImm(opOut, 2, 0, 0));
            prog.push_back(encodeImm(opOut, 3, 0, 0));
        end
        // countdown loop with a backward branch.
        prog.push_back(encodeImm(opAddi, 4, 0, 3 + $urandom_range(0, 3)));
        prog.push_back(encodeImm(opOut, 4, 0, 0));
        prog.push_back(encodeImm(opAddi, 4, 4, -1));
        prog.push_back(encodeBranch(4, 2'd1, -3));
        prog.push_back(encodeImm(opHalt, 0, 0, 0));
    endtask

    task automatic buildJrProgram();
        int target;
        target = 4 * $urandom_range(8, 15);
        prog.delete();
        prog.push_back(encodeImm(opAddi, 6, 0, 32'hbad));
        prog.push_back(encodeImm(opAddi, 7, 0, $urandom));
        prog.push_back(encodeImm(opAddi, 5, 0, target));
        prog.push_back(encodeImm(opJr, 5, 0, 0));
        while (prog.size() < target) begin
            prog.push_back(encodeImm(opOut, 6, 0, 0));  // must be skipped.
        end
        prog.push_back(encodeImm(opOut, 7, 0, 0));
        prog.push_back(encodeImm(opOut, 5, 0, 0));
        prog.push_back(encodeImm(opHalt, 0, 0, 0));
    endtask

    initial begin
        int errBefore;
        void'($urandom(32'hf2bb));
        buildAluProgram();
        runProgram("alu", 1'b0);
        buildMemProgram();
        runProgram("load store", 1'b0);
        buildBranchProgram();
        runProgram("branch", 1'b0);
        buildJrProgram();
        runProgram("jump register", 1'b0);

        // same program under fixed then random latency.
        buildMemProgram();
        runProgram("latency fixed", 1'b1);
        firstOut = actOut;
        runProgram("latency random", 1'b0);
        errBefore = errors;
        checkValue("latency out count", actOut.size(), firstOut.size());
        for (int i = 0; i < actOut.size() && i < firstOut.size(); i++) begin
            checkValue($sformatf("latency outData[%0d]", i), actOut[i], firstOut[i]);
        end
        tests++;
        $display("%-16s %0d outs, %s", "latency compare", firstOut.size(),
                 (errors == errBefore) ? "ok" : "mismatch");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

`default_nettype wire
